// ==== all.f ====
rtl/layer_pkg.sv
rtl/power_seq_timer.sv
rtl/layer_ctrl_fsm.sv
rtl/rf_ctrl.sv
rtl/mem_ctrl.sv
rtl/layer_wrapper.sv
dv/layer_wrapper_properties.sv
dv/layer_wrapper_tb.sv

// ==== dv/layer_wrapper_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_wrapper_tb;

	localparam int RF_DEPTH    = 64;
	localparam int MEM_DEPTH   = 256;
	localparam int WAKE_CYCLES = 4;
	localparam int MEM_LATENCY = 2;
	localparam int MAX_DELAY   = 5;
	// One edge to sample the request, then three timed wake steps
	localparam int WAKE_EDGES  = 3 * (WAKE_CYCLES + 1) + 1;
	localparam int MSG_COST    = MEM_LATENCY + 2 * MAX_DELAY + 20;

	typedef struct packed {
		layer_pkg::op_e                   op;
		logic [layer_pkg::ADDR_WIDTH-1:0] addr;
		logic [layer_pkg::DATA_WIDTH-1:0] data;
		logic                             has_reply;
		logic [layer_pkg::DATA_WIDTH-1:0] exp_data;
	} row_t;

	logic                clk;
	logic                arst_n;
	logic                rx_req;
	layer_pkg::bus_msg_t rx_msg;
	logic                rx_ack;
	logic                tx_req;
	layer_pkg::reply_t   tx_msg;
	logic                tx_ack;
	logic                pwr_on;

	row_t                                rows_q[$];
	layer_pkg::reply_t                   replies[$];
	logic [layer_pkg::RF_DATA_WIDTH-1:0] ref_rf [RF_DEPTH];
	logic [layer_pkg::DATA_WIDTH-1:0]    ref_mem [MEM_DEPTH];
	integer                              seed = 32'hbeb9f3bf;
	int                                  error_count;
	int                                  check_count;
	int                                  wake_count;
	int                                  cycle_count;
	int                                  cycle_limit;

	layer_wrapper #(
		.RF_DEPTH    (RF_DEPTH),
		.MEM_DEPTH   (MEM_DEPTH),
		.WAKE_CYCLES (WAKE_CYCLES),
		.MEM_LATENCY (MEM_LATENCY)
	) i_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.rx_req (rx_req),
		.rx_msg (rx_msg),
		.rx_ack (rx_ack),
		.tx_req (tx_req),
		.tx_msg (tx_msg),
		.tx_ack (tx_ack),
		.pwr_on (pwr_on)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: the run was still going after %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp_val);
		check_count++;
		if (got !== exp_val)
		begin
			error_count++;
			$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp_val);
		end
	endtask

	// Reference model: registers keep 24 bits, addresses wrap by depth
	task automatic add_row(input layer_pkg::op_e op, input logic [15:0] addr,
		input logic [31:0] data);
		row_t row;
		int   rf_idx;
		int   mem_idx;
		row.op = op;
		row.addr = addr;
		row.data = data;
		row.has_reply = 1'b0;
		row.exp_data = '0;
		rf_idx = addr % RF_DEPTH;
		mem_idx = addr % MEM_DEPTH;
		case (op)
			layer_pkg::OP_RF_WRITE:  ref_rf[rf_idx] = data[23:0];
			layer_pkg::OP_MEM_WRITE: ref_mem[mem_idx] = data;
			layer_pkg::OP_RF_READ:
			begin
				row.has_reply = 1'b1;
				row.exp_data = {8'h00, ref_rf[rf_idx]};
			end
			layer_pkg::OP_MEM_READ:
			begin
				row.has_reply = 1'b1;
				row.exp_data = ref_mem[mem_idx];
			end
			default:                 wake_count++;
		endcase
		rows_q.push_back(row);
	endtask

	task automatic run_row(input row_t row);
		int                n;
		logic              asleep;
		logic              woke;
		layer_pkg::reply_t got;
		@(negedge clk);
		asleep = !pwr_on;
		woke = 1'b0;
		@(posedge clk);
		rx_msg.op <= row.op;
		rx_msg.addr <= row.addr;
		rx_msg.data <= row.data;
		rx_req <= 1'b1;
		// Edges counted from the one that drives rx_req
		n = 0;
		do
		begin
			@(posedge clk);
			n++;
			@(negedge clk);
			if (asleep && !woke && pwr_on)
			begin
				woke = 1'b1;
				check("wake edges", n, WAKE_EDGES);
				check("rx_ack at wake", rx_ack, 1'b0);
			end
		end
		while (!rx_ack);
		if (asleep)
		begin
			check("wake seen", woke, 1'b1);
		end
		else if (row.op == layer_pkg::OP_RF_WRITE || row.op == layer_pkg::OP_SLEEP)
		begin
			check("rx_ack latency", n, 2);
		end
		else if (row.op == layer_pkg::OP_MEM_WRITE)
		begin
			check("rx_ack latency", n, MEM_LATENCY + 3);
		end
		check("pwr_on", pwr_on, 1'b1);
		check("tx_ack at rx_ack", tx_ack, 1'b0);
		check("reply count", replies.size(), row.has_reply);
		if (row.has_reply && replies.size() > 0)
		begin
			got = replies.pop_front();
			check("tx_msg.addr", got.addr, row.addr);
			check("tx_msg.data", got.data, row.exp_data);
		end
		replies.delete();
		@(posedge clk);
		rx_req <= 1'b0;
		do
		begin
			@(negedge clk);
		end
		while (rx_ack);
		if (row.op == layer_pkg::OP_SLEEP)
		begin
			check("pwr_on after sleep", pwr_on, 1'b0);
		end
	endtask

	// Bus node side of the reply handshake with random hold-off
	initial
	begin
		int delay;
		forever
		begin
			@(negedge clk);
			if (tx_req)
			begin
				delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
				repeat (delay) @(negedge clk);
				replies.push_back(tx_msg);
				@(posedge clk);
				tx_ack <= 1'b1;
				do
				begin
					@(negedge clk);
				end
				while (tx_req);
				@(posedge clk);
				tx_ack <= 1'b0;
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b1;
		rx_req = 1'b0;
		rx_msg = '0;
		tx_ack = 1'b0;
		wake_count = 1;
		for (int i = 0; i < RF_DEPTH; i++)
		begin
			ref_rf[i] = '0;
		end
		add_row(layer_pkg::OP_RF_WRITE, 16'h0005, 32'hA5123456);
		add_row(layer_pkg::OP_RF_READ, 16'h0005, 32'h0);
		add_row(layer_pkg::OP_RF_WRITE, 16'h0045, 32'hFFABCDEF);
		add_row(layer_pkg::OP_RF_READ, 16'h0005, 32'h0);
		add_row(layer_pkg::OP_RF_READ, 16'h0045, 32'h0);
		add_row(layer_pkg::OP_RF_READ, 16'h0007, 32'h0);
		add_row(layer_pkg::OP_MEM_WRITE, 16'h0010, 32'hDEADBEEF);
		add_row(layer_pkg::OP_MEM_WRITE, 16'h0011, 32'h01234567);
		add_row(layer_pkg::OP_MEM_WRITE, 16'h0110, 32'hCAFEF00D);
		add_row(layer_pkg::OP_MEM_WRITE, 16'h00FF, 32'h89ABCDEF);
		add_row(layer_pkg::OP_MEM_READ, 16'h0010, 32'h0);
		add_row(layer_pkg::OP_MEM_READ, 16'h0011, 32'h0);
		add_row(layer_pkg::OP_MEM_READ, 16'h01FF, 32'h0);
		add_row(layer_pkg::OP_RF_WRITE, 16'h003F, 32'h00FEDCBA);
		add_row(layer_pkg::OP_SLEEP, 16'h0000, 32'h0);
		add_row(layer_pkg::OP_RF_READ, 16'h003F, 32'h0);
		add_row(layer_pkg::OP_SLEEP, 16'h0000, 32'h0);
		add_row(layer_pkg::OP_MEM_READ, 16'h0011, 32'h0);
		add_row(layer_pkg::OP_RF_READ, 16'h0045, 32'h0);
		cycle_limit = 8 + rows_q.size() * MSG_COST + wake_count * WAKE_EDGES;
		#2 arst_n = 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check("pwr_on after reset", pwr_on, 1'b0);
		check("rx_ack after reset", rx_ack, 1'b0);
		check("tx_req after reset", tx_req, 1'b0);
		for (int i = 0; i < rows_q.size(); i++)
		begin
			run_row(rows_q[i]);
		end
		$display("Run finished: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/layer_wrapper_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_wrapper_properties (
	input wire logic              clk,
	input wire logic              arst_n,
	input wire logic              rx_req,
	input wire logic              rx_ack,
	input wire logic              tx_req,
	input wire layer_pkg::reply_t tx_msg,
	input wire logic              pwr_on
);

	// An ack only ever answers a pending request
	rx_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(rx_ack) |-> rx_req)
		else $error("rx_ack rose while rx_req was low");

	// Reply payload frozen for the whole tx handshake
	tx_msg_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(tx_req && $past(tx_req)) |-> $stable(tx_msg))
		else $error("tx_msg changed while tx_req was high");

	// No replies from a powered-down layer
	tx_req_needs_pwr: assert property (@(posedge clk) disable iff (!arst_n)
		tx_req |-> pwr_on)
		else $error("tx_req high while pwr_on low");

	reset_quiet: assert property (@(posedge clk)
		!arst_n |-> (!rx_ack && !tx_req))
		else $error("rx_ack or tx_req high during reset");

endmodule

bind layer_wrapper layer_wrapper_properties u_props (
	.clk    (clk),
	.arst_n (arst_n),
	.rx_req (rx_req),
	.rx_ack (rx_ack),
	.tx_req (tx_req),
	.tx_msg (tx_msg),
	.pwr_on (pwr_on)
);

`default_nettype wire

// ==== rtl/layer_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_wrapper #(
	parameter int RF_DEPTH    = 64,
	parameter int MEM_DEPTH   = 256,
	parameter int WAKE_CYCLES = 4,
	parameter int MEM_LATENCY = 2
) (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire logic                rx_req,
	input  wire layer_pkg::bus_msg_t rx_msg,
	output logic                     rx_ack,
	output logic                     tx_req,
	output layer_pkg::reply_t        tx_msg,
	input  wire logic                tx_ack,
	output logic                     pwr_on
);

	// Timer sharing
	logic       ctrl_tmr_load;
	logic       mem_tmr_load;
	logic [7:0] ctrl_tmr_count;
	logic       tmr_load;
	logic [7:0] tmr_count;
	logic       tmr_expired;

	// Register file port
	layer_pkg::rf_wr_t                   rf_wr;
	logic [$clog2(RF_DEPTH)-1:0]         rf_rd_addr;
	logic [layer_pkg::RF_DATA_WIDTH-1:0] rf_rd_data;

	// Memory port
	logic                             mem_req;
	layer_pkg::mem_req_t              mem_cmd;
	logic                             mem_ack;
	logic [layer_pkg::DATA_WIDTH-1:0] mem_rd_data;

	// Wake steps and memory waits never overlap
	assign tmr_load  = ctrl_tmr_load | mem_tmr_load;
	assign tmr_count = mem_tmr_load ? 8'(MEM_LATENCY) : ctrl_tmr_count;

	layer_ctrl_fsm #(
		.WAKE_CYCLES (WAKE_CYCLES),
		.RF_DEPTH    (RF_DEPTH)
	) u_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.rx_req      (rx_req),
		.rx_msg      (rx_msg),
		.rx_ack      (rx_ack),
		.tx_req      (tx_req),
		.tx_msg      (tx_msg),
		.tx_ack      (tx_ack),
		.pwr_on      (pwr_on),
		.tmr_load    (ctrl_tmr_load),
		.tmr_count   (ctrl_tmr_count),
		.tmr_expired (tmr_expired),
		.rf_wr       (rf_wr),
		.rf_rd_addr  (rf_rd_addr),
		.rf_rd_data  (rf_rd_data),
		.mem_req     (mem_req),
		.mem_cmd     (mem_cmd),
		.mem_ack     (mem_ack),
		.mem_rd_data (mem_rd_data)
	);

	power_seq_timer u_timer (
		.clk     (clk),
		.arst_n  (arst_n),
		.load    (tmr_load),
		.count   (tmr_count),
		.expired (tmr_expired)
	);

	// Always-on storage
	rf_ctrl #(
		.RF_DEPTH (RF_DEPTH)
	) u_rf (
		.clk     (clk),
		.arst_n  (arst_n),
		.rf_wr   (rf_wr),
		.rd_addr (rf_rd_addr),
		.rd_data (rf_rd_data)
	);

	mem_ctrl #(
		.MEM_DEPTH   (MEM_DEPTH),
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk         (clk),
		.arst_n      (arst_n),
		.mem_req     (mem_req),
		.mem_cmd     (mem_cmd),
		.mem_ack     (mem_ack),
		.rd_data     (mem_rd_data),
		.tmr_load    (mem_tmr_load),
		.tmr_expired (tmr_expired)
	);

endmodule

`default_nettype wire

// ==== rtl/mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl #(
	parameter int MEM_DEPTH   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  wire logic                              clk,
	input  wire logic                              arst_n,
	input  wire logic                              mem_req,
	input  wire layer_pkg::mem_req_t               mem_cmd,
	output logic                                   mem_ack,
	output logic [layer_pkg::DATA_WIDTH-1:0]       rd_data,
	output logic                                   tmr_load,
	input  wire logic                              tmr_expired
);

	localparam int MEM_AW = $clog2(MEM_DEPTH);

	logic [layer_pkg::DATA_WIDTH-1:0] mem [MEM_DEPTH];
	logic [MEM_AW-1:0]                word_addr;
	logic                             req_q;

	// The shared timer is only 8 bits wide
	if (MEM_LATENCY < 0 || MEM_LATENCY > 255)
	begin : g_latency_range
		$error("MEM_LATENCY out of the 8-bit timer range");
	end

	assign word_addr = mem_cmd.addr[MEM_AW-1:0];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			req_q <= 1'b0;
		end
		else
		begin
			req_q <= mem_req;
		end
	end

	// Rising request starts the access wait
	assign tmr_load = mem_req && !req_q;

	// Ack holds while the timer sits at zero and falls with the request
	assign mem_ack = mem_req && req_q && tmr_expired;

	always_ff @(posedge clk)
	begin
		if (mem_ack && mem_cmd.write)
		begin
			mem[word_addr] <= mem_cmd.data;
		end
	end

	// Read word sampled while the request waits, ready when ack rises
	always_ff @(posedge clk)
	begin
		if (mem_req && !mem_cmd.write && !mem_ack)
		begin
			rd_data <= mem[word_addr];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rf_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_ctrl #(
	parameter int RF_DEPTH = 64
) (
	input  wire logic                                clk,
	input  wire logic                                arst_n,
	input  wire layer_pkg::rf_wr_t                   rf_wr,
	input  wire logic [$clog2(RF_DEPTH)-1:0]         rd_addr,
	output logic [layer_pkg::RF_DATA_WIDTH-1:0]      rd_data
);

	localparam int RF_AW = $clog2(RF_DEPTH);

	logic [layer_pkg::RF_DATA_WIDTH-1:0] regs [RF_DEPTH];
	logic [RF_AW-1:0]                    wr_idx;

	// Upper address bits are ignored, so large addresses wrap
	assign wr_idx = rf_wr.addr[RF_AW-1:0];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < RF_DEPTH; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (rf_wr.en)
		begin
			regs[wr_idx] <= rf_wr.data;
		end
	end

	assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// ==== rtl/layer_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_ctrl_fsm #(
	parameter int WAKE_CYCLES = 4,
	parameter int RF_DEPTH    = 64
) (
	input  wire logic                                  clk,
	input  wire logic                                  arst_n,
	input  wire logic                                  rx_req,
	input  wire layer_pkg::bus_msg_t                   rx_msg,
	output logic                                       rx_ack,
	output logic                                       tx_req,
	output layer_pkg::reply_t                          tx_msg,
	input  wire logic                                  tx_ack,
	output logic                                       pwr_on,
	output logic                                       tmr_load,
	output logic [7:0]                                 tmr_count,
	input  wire logic                                  tmr_expired,
	output layer_pkg::rf_wr_t                          rf_wr,
	output logic [$clog2(RF_DEPTH)-1:0]                rf_rd_addr,
	input  wire logic [layer_pkg::RF_DATA_WIDTH-1:0]   rf_rd_data,
	output logic                                       mem_req,
	output layer_pkg::mem_req_t                        mem_cmd,
	input  wire logic                                  mem_ack,
	input  wire logic [layer_pkg::DATA_WIDTH-1:0]      mem_rd_data
);

	localparam int RF_AW = $clog2(RF_DEPTH);

	layer_pkg::state_e   state;
	layer_pkg::state_e   state_nxt;
	layer_pkg::bus_msg_t msg_q;
	logic                is_mem_op;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= layer_pkg::ST_SLEEP;
		end
		else
		begin
			state <= state_nxt;
		end
	end

	// Message is held by the bus node until rx_ack, one copy is enough
	always_ff @(posedge clk)
	begin
		if (state == layer_pkg::ST_IDLE && rx_req)
		begin
			msg_q <= rx_msg;
		end
	end

	// Reply payload, frozen for the whole tx handshake
	always_ff @(posedge clk)
	begin
		if (state == layer_pkg::ST_EXEC && msg_q.op == layer_pkg::OP_RF_READ)
		begin
			tx_msg.addr <= msg_q.addr;
			tx_msg.data <= layer_pkg::DATA_WIDTH'(rf_rd_data);
		end
		else if (state == layer_pkg::ST_MEM_WAIT && mem_ack)
		begin
			tx_msg.addr <= msg_q.addr;
			tx_msg.data <= mem_rd_data;
		end
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			layer_pkg::ST_SLEEP:
			begin
				if (rx_req)
				begin
					state_nxt = layer_pkg::ST_WAKE_ISO;
				end
			end
			layer_pkg::ST_WAKE_ISO:
			begin
				if (tmr_expired)
				begin
					state_nxt = layer_pkg::ST_WAKE_CLK;
				end
			end
			layer_pkg::ST_WAKE_CLK:
			begin
				if (tmr_expired)
				begin
					state_nxt = layer_pkg::ST_WAKE_RST;
				end
			end
			layer_pkg::ST_WAKE_RST:
			begin
				if (tmr_expired)
				begin
					state_nxt = layer_pkg::ST_IDLE;
				end
			end
			layer_pkg::ST_IDLE:
			begin
				if (rx_req)
				begin
					state_nxt = layer_pkg::ST_EXEC;
				end
			end
			layer_pkg::ST_EXEC:
			begin
				case (msg_q.op)
					layer_pkg::OP_RF_READ:   state_nxt = layer_pkg::ST_REPLY;
					layer_pkg::OP_MEM_WRITE: state_nxt = layer_pkg::ST_MEM_WAIT;
					layer_pkg::OP_MEM_READ:  state_nxt = layer_pkg::ST_MEM_WAIT;
					// register writes, sleep and unknown opcodes go straight to ack
					default:                 state_nxt = layer_pkg::ST_ACK;
				endcase
			end
			layer_pkg::ST_MEM_WAIT:
			begin
				if (mem_ack)
				begin
					if (msg_q.op == layer_pkg::OP_MEM_READ)
					begin
						state_nxt = layer_pkg::ST_REPLY;
					end
					else
					begin
						state_nxt = layer_pkg::ST_ACK;
					end
				end
			end
			layer_pkg::ST_REPLY:
			begin
				if (tx_ack)
				begin
					state_nxt = layer_pkg::ST_REPLY_DONE;
				end
			end
			layer_pkg::ST_REPLY_DONE:
			begin
				if (!tx_ack)
				begin
					state_nxt = layer_pkg::ST_ACK;
				end
			end
			layer_pkg::ST_ACK:
			begin
				if (!rx_req)
				begin
					if (msg_q.op == layer_pkg::OP_SLEEP)
					begin
						state_nxt = layer_pkg::ST_SLEEP;
					end
					else
					begin
						state_nxt = layer_pkg::ST_IDLE;
					end
				end
			end
			default:
			begin
				state_nxt = layer_pkg::ST_SLEEP;
			end
		endcase
	end

	// Handshake and power outputs decode the state directly
	assign rx_ack = (state == layer_pkg::ST_ACK);
	assign tx_req = (state == layer_pkg::ST_REPLY);
	assign pwr_on = (state != layer_pkg::ST_SLEEP) && (state != layer_pkg::ST_WAKE_ISO)
		&& (state != layer_pkg::ST_WAKE_CLK) && (state != layer_pkg::ST_WAKE_RST);

	// Each wake step restarts the timer as it begins
	assign tmr_load = (state == layer_pkg::ST_SLEEP && rx_req)
		|| (state == layer_pkg::ST_WAKE_ISO && tmr_expired)
		|| (state == layer_pkg::ST_WAKE_CLK && tmr_expired);
	assign tmr_count = 8'(WAKE_CYCLES);

	assign rf_wr.en   = (state == layer_pkg::ST_EXEC) && (msg_q.op == layer_pkg::OP_RF_WRITE);
	assign rf_wr.addr = msg_q.addr;
	assign rf_wr.data = msg_q.data[layer_pkg::RF_DATA_WIDTH-1:0];
	assign rf_rd_addr = msg_q.addr[RF_AW-1:0];

	// Request level starts in EXEC and is held until the ack
	assign is_mem_op = (msg_q.op == layer_pkg::OP_MEM_WRITE) || (msg_q.op == layer_pkg::OP_MEM_READ);
	assign mem_req = is_mem_op
		&& (state == layer_pkg::ST_EXEC || state == layer_pkg::ST_MEM_WAIT);
	assign mem_cmd.write = (msg_q.op == layer_pkg::OP_MEM_WRITE);
	assign mem_cmd.addr  = msg_q.addr;
	assign mem_cmd.data  = msg_q.data;

endmodule

`default_nettype wire

// ==== rtl/power_seq_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module power_seq_timer (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic       load,
	input  wire logic [7:0] count,
	output logic            expired
);

	logic [7:0] cnt;

	// Reload wins over counting down
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt <= '0;
		end
		else if (load)
		begin
			cnt <= count;
		end
		else if (cnt != '0)
		begin
			cnt <= cnt - 8'd1;
		end
	end

	// Loaded as a step begins, so a step lasts count + 1 cycles
	assign expired = (cnt == '0);

endmodule

`default_nettype wire

// ==== rtl/layer_pkg.sv ====
`default_nettype none

package layer_pkg;

	// Bus word, register and message address widths
	localparam int DATA_WIDTH    = 32;
	localparam int RF_DATA_WIDTH = 24;
	localparam int ADDR_WIDTH    = 16;

	typedef enum logic [2:0] {
		OP_RF_WRITE  = 3'd0,
		OP_RF_READ   = 3'd1,
		OP_MEM_WRITE = 3'd2,
		OP_MEM_READ  = 3'd3,
		OP_SLEEP     = 3'd4
	} op_e;

	// Wake steps first, then the awake states
	typedef enum logic [3:0] {
		ST_SLEEP      = 4'd0,
		ST_WAKE_ISO   = 4'd1,
		ST_WAKE_CLK   = 4'd2,
		ST_WAKE_RST   = 4'd3,
		ST_IDLE       = 4'd4,
		ST_EXEC       = 4'd5,
		ST_MEM_WAIT   = 4'd6,
		ST_REPLY      = 4'd7,
		ST_REPLY_DONE = 4'd8,
		ST_ACK        = 4'd9
	} state_e;

	typedef struct packed {
		op_e                   op;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} bus_msg_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} reply_t;

	typedef struct packed {
		logic                     en;
		logic [ADDR_WIDTH-1:0]    addr;
		logic [RF_DATA_WIDTH-1:0] data;
	} rf_wr_t;

	typedef struct packed {
		logic                  write;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} mem_req_t;

endpackage

`default_nettype wire
